// ==== files.f ====
rtl/l15_pkg.sv
rtl/l15_arb_ctrl.sv
rtl/l15_port_steer.sv
rtl/l15_arb_regs.sv
rtl/l15_port_share.sv
sim/l15_port_share_chk.sv
sim/tb_l15_port_share.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_l15_port_share
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_l15_port_share.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l15_port_share;
	import l15_pkg::*;

	localparam int addr_w = 32;
	localparam int data_w = 64;

	logic                 clk;
	logic                 nrst;
	logic [rqtype_w-1:0]  l15_rqtype, if_rqtype, dm_rqtype;
	logic [size_w-1:0]    l15_size, if_size, dm_size;
	logic [addr_w-1:0]    l15_address, if_address, dm_address;
	logic [data_w-1:0]    l15_data, if_data, dm_data;
	logic [data_w-1:0]    l15_data_0, l15_data_1, if_data_0, if_data_1, dm_data_0, dm_data_1;
	logic [rettype_w-1:0] l15_returntype, if_returntype, dm_returntype;
	logic                 l15_val, l15_req_ack, l15_ack, l15_header_ack, l15_resp_val;
	logic                 if_val, if_req_ack, if_ack, if_header_ack, if_resp_val, if_hold;
	logic                 dm_val, dm_req_ack, dm_pending, dm_ack, dm_header_ack, dm_resp_val;
	logic                 dm_grant, psel, penable, pwrite, pready, pslverr, cache_rdy;
	logic [apb_aw-1:0]    paddr;
	logic [31:0]          pwdata, prdata;

	arb_state_t  m_state;  // Reference owner
	logic        m_den, m_wd;
	logic [31:0] m_dwin, m_iresp;
	int          m_out, win_total;
	logic [31:0] lcg_state;
	int          resp_due, resp_wait, d_phase;
	logic        f_acked, d_acked, d_resp_seen, grant_seen, hold_seen;

	// Cache takes a request in any cycle it is ready
	assign l15_ack = l15_val && cache_rdy;

	l15_port_share #(.addr_w(addr_w), .data_w(data_w)) l15_port_share_i (.*);

	bind l15_port_share l15_port_share_chk chk_i (
		.clk(clk), .nrst(nrst), .dm_grant(dm_grant), .if_hold(if_hold),
		.if_ack(if_ack), .dm_ack(dm_ack), .l15_val(l15_val)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {lcg_state[15:0], lcg_state[31:16]};  // High bits are the better ones
	endfunction

	function automatic logic [63:0] rand64();
		return {lcg_next(), lcg_next()};
	endfunction

	task automatic fail_check(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Errors found");
		$fatal(1, "stopped on timeout");
	endtask

	// Cache, fetch and data memory models driven on the rising edge
	task automatic drive_models();
		cache_rdy      <= (lcg_next() % 2) == 0;
		l15_header_ack <= (lcg_next() % 2) == 0;
		if (resp_due > 0 && resp_wait == 0)
		begin
			l15_resp_val   <= 1'b1;
			l15_data_0     <= rand64();
			l15_data_1     <= rand64();
			l15_returntype <= rettype_w'(lcg_next());
			resp_due--;
			resp_wait = lcg_next() % 4;
		end
		else
		begin
			l15_resp_val <= 1'b0;
			if (resp_wait > 0)
				resp_wait--;
		end
		if_req_ack <= (lcg_next() % 2) == 1;
		dm_req_ack <= (lcg_next() % 2) == 1;
		if (!if_val || f_acked)  // Fetch holds its request until acked
		begin
			if (!hold_seen && m_out < 8 && (lcg_next() % 3) == 0)
			begin
				if_val     <= 1'b1;
				if_address <= lcg_next();
				if_rqtype  <= rqtype_w'(lcg_next());
				if_size    <= size_w'(lcg_next());
				if_data    <= rand64();
			end
			else
				if_val <= 1'b0;
		end
		case (d_phase)
			0: if ((lcg_next() % 12) == 0)
			begin
				dm_pending <= 1'b1;
				d_phase = 1;
			end
			1: if (grant_seen)
			begin
				dm_val     <= 1'b1;
				dm_address <= lcg_next();
				dm_rqtype  <= rqtype_w'(lcg_next());
				dm_size    <= size_w'(lcg_next());
				dm_data    <= rand64();
				d_phase = 2;
			end
			2: if (d_acked)
			begin
				dm_val     <= 1'b0;
				dm_pending <= 1'b0;
				d_phase = 3;
			end
			default: if (d_resp_seen)
				d_phase = 0;
		endcase
	endtask

	task automatic check_outputs();
		logic        own_dm;
		logic        mapped;
		logic [31:0] exp_rd;
		own_dm = (m_state == arb_mem);
		assert (dm_grant == own_dm && if_hold == (m_state != arb_instr))
			else fail_check("dm_grant or if_hold disagrees with the model owner");
		assert (!(dm_grant && m_out != 0))
			else fail_check("dm_grant high with fetch requests outstanding");
		assert (l15_val == (m_state == arb_instr ? if_val : (own_dm && dm_val)))
			else fail_check("l15_val does not follow the owner");
		assert (!l15_val || (own_dm ? {l15_address, l15_rqtype, l15_size, l15_data} ==
			{dm_address, dm_rqtype, dm_size, dm_data} : {l15_address, l15_rqtype, l15_size,
			l15_data} == {if_address, if_rqtype, if_size, if_data}))
			else fail_check("request fields differ from the owner's");
		assert (if_ack == (l15_ack && m_state == arb_instr) && dm_ack == (l15_ack && own_dm))
			else fail_check("acknowledge routed to the wrong client");
		assert (if_header_ack == (l15_header_ack && m_state == arb_instr)
			&& dm_header_ack == (l15_header_ack && own_dm))
			else fail_check("header acknowledge routed to the wrong client");
		assert (if_resp_val == (l15_resp_val && !own_dm)
			&& dm_resp_val == (l15_resp_val && own_dm))
			else fail_check("response valid routed to the wrong client");
		assert (!l15_resp_val || ({if_data_0, if_data_1, if_returntype} ==
			{l15_data_0, l15_data_1, l15_returntype} && {dm_data_0, dm_data_1, dm_returntype} ==
			{l15_data_0, l15_data_1, l15_returntype}))
			else fail_check("response data changed on the way to the client");
		assert (l15_req_ack == (own_dm ? dm_req_ack : if_req_ack))
			else fail_check("l15_req_ack not taken from the owner");
		mapped = (paddr == reg_ctrl) || (paddr == reg_dwin) || (paddr == reg_iresp);
		assert (pready && pslverr == (psel && penable && !mapped))
			else fail_check($sformatf("pready %0b pslverr %0b at offset %0h",
				pready, pslverr, paddr));
		if (psel && penable && !pwrite && mapped)
		begin
			exp_rd = (paddr == reg_ctrl) ? {31'd0, m_den}
				: ((paddr == reg_dwin) ? m_dwin : m_iresp);
			assert (prdata == exp_rd)
				else fail_check($sformatf("offset %0h read %0h, expected %0h",
					paddr, prdata, exp_rd));
		end
	endtask

	// Advances the model by the clock edge that follows
	task automatic update_model();
		logic       acc;
		logic       f_resp;
		logic       mem_done;
		arb_state_t nxt;
		acc      = l15_val && l15_ack;
		f_resp   = l15_resp_val && (m_state != arb_mem);
		mem_done = (m_state == arb_mem) && (l15_resp_val || l15_ack) && !dm_pending;
		nxt = m_state;
		if (m_state == arb_instr && dm_pending && m_den)
			nxt = arb_wait;
		else if (m_state == arb_wait && m_out == 0)
			nxt = arb_mem;
		else if (mem_done)
			nxt = arb_instr;
		if (acc)
		begin
			if (resp_due == 0)
				resp_wait = lcg_next() % 4;
			resp_due++;
		end
		if (acc && m_state == arb_instr)
			m_out++;
		if (f_resp)
			m_out--;
		if (psel && penable && pwrite && paddr == reg_ctrl)
			m_den = pwdata[0];
		if (psel && penable && pwrite && paddr == reg_dwin)
			m_dwin = '0;
		else if (m_wd)
			m_dwin = m_dwin + 32'd1;  // Pulse lands one cycle after the window
		if (psel && penable && pwrite && paddr == reg_iresp)
			m_iresp = '0;
		else if (f_resp)
			m_iresp = m_iresp + 32'd1;
		m_wd = mem_done;
		if (mem_done)
			win_total++;
		m_state     = nxt;
		f_acked     = if_ack;
		d_acked     = dm_ack;
		d_resp_seen = dm_resp_val;
		grant_seen  = dm_grant;
		hold_seen   = if_hold;
	endtask

	task automatic step_cycle(input logic sel, input logic en, input logic wr,
		input logic [apb_aw-1:0] addr, input logic [31:0] wdata);
		@(posedge clk);
		drive_models();
		psel    <= sel;
		penable <= en;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(negedge clk);  // Outputs settled here
		check_outputs();
		update_model();
	endtask

	task automatic run_idle(input int n);
		repeat (n)
			step_cycle(1'b0, 1'b0, 1'b0, '0, '0);
	endtask

	// Setup then access, access phase left on the bus
	task automatic apb_access(input logic wr, input logic [apb_aw-1:0] addr,
		input logic [31:0] wdata);
		step_cycle(1'b1, 1'b0, wr, addr, wdata);
		step_cycle(1'b1, 1'b1, wr, addr, wdata);
	endtask

	initial
	begin
		int n;
		clk = 1'b0;
		nrst = 1'b0;
		{if_rqtype, if_size, if_address, if_data, if_val, if_req_ack} = '0;
		{dm_rqtype, dm_size, dm_address, dm_data, dm_val, dm_req_ack, dm_pending} = '0;
		{l15_resp_val, l15_header_ack, l15_data_0, l15_data_1, l15_returntype} = '0;
		cache_rdy = 1'b0;
		{psel, penable, pwrite, paddr, pwdata} = '0;
		lcg_state = 32'd5702;
		m_state = arb_instr;
		m_den = 1'b1;
		{m_wd, m_dwin, m_iresp, f_acked, d_acked, d_resp_seen, grant_seen, hold_seen} = '0;
		{m_out, win_total, resp_due, resp_wait, d_phase} = '0;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		assert (!l15_val && !dm_grant && !if_hold && !pslverr)
			else fail_check("outputs not idle after reset");
		apb_access(1'b0, reg_ctrl, '0);
		assert (prdata == 32'd1)
			else fail_check($sformatf("CTRL read %0h after reset", prdata));
		for (int i = 0; i < 600; i++)
		begin
			if (i % 60 == 59)
			begin
				apb_access(1'b0, reg_dwin, '0);
				apb_access(1'b0, reg_iresp, '0);
			end
			else
				run_idle(1);
		end
		assert (win_total > 0) else fail_check("no data window completed under random traffic");
		// Pending data requests starve with data enable off
		apb_access(1'b1, reg_ctrl, 32'd0);
		n = 0;
		while ((m_state != arb_instr || !dm_pending) && n < 300)
		begin
			run_idle(1);
			n++;
		end
		if (m_state != arb_instr || !dm_pending)
			stop_on_timeout("no pending data request with the arbiter in INSTR");
		repeat (40)
		begin
			run_idle(1);
			assert (!dm_grant) else fail_check("dm_grant rose with data enable cleared");
		end
		apb_access(1'b1, reg_ctrl, 32'd1);
		n = 0;
		while (!dm_grant && n < 200)
		begin
			run_idle(1);
			n++;
		end
		if (!dm_grant)
			stop_on_timeout("dm_grant did not rise after data enable was set");
		apb_access(1'b1, reg_dwin, 32'hffff_ffff);  // Any data clears
		apb_access(1'b1, reg_iresp, 32'h1234_5678);
		apb_access(1'b0, reg_dwin, '0);
		apb_access(1'b0, reg_iresp, '0);
		apb_access(1'b0, 4'hc, '0);
		assert (pslverr) else fail_check("unmapped read did not set pslverr");
		run_idle(300);
		apb_access(1'b0, reg_dwin, '0);
		apb_access(1'b0, reg_iresp, '0);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/l15_port_share_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module l15_port_share_chk (
	input logic clk,
	input logic nrst,
	input logic dm_grant,
	input logic if_hold,
	input logic if_ack,
	input logic dm_ack,
	input logic l15_val
);

	// Fetch must be held back whenever data memory owns the port
	grant_needs_hold: assert property (@(posedge clk) disable iff (!nrst)
		dm_grant |-> if_hold)
		else $error("dm_grant high while if_hold is low");

	// Acknowledge goes to one client only
	single_ack: assert property (@(posedge clk) disable iff (!nrst)
		!(if_ack && dm_ack))
		else $error("acknowledge reached fetch and data memory together");

	// Port stays idle while fetch responses drain
	idle_in_wait: assert property (@(posedge clk) disable iff (!nrst)
		(if_hold && !dm_grant) |-> !l15_val)
		else $error("l15_val high during the drain phase");

endmodule

`default_nettype wire

// ==== rtl/l15_port_share.sv ====
`timescale 1ns/1ps
`default_nettype none

module l15_port_share #(
	parameter int addr_w = 32,
	parameter int data_w = 64
) (
	input  logic                          clk,
	input  logic                          nrst,
	// L1.5 port
	output logic [l15_pkg::rqtype_w-1:0]  l15_rqtype,
	output logic [l15_pkg::size_w-1:0]    l15_size,
	output logic [addr_w-1:0]             l15_address,
	output logic [data_w-1:0]             l15_data,
	output logic                          l15_val,
	output logic                          l15_req_ack,
	input  logic                          l15_ack,
	input  logic                          l15_header_ack,
	input  logic                          l15_resp_val,
	input  logic [data_w-1:0]             l15_data_0,
	input  logic [data_w-1:0]             l15_data_1,
	input  logic [l15_pkg::rettype_w-1:0] l15_returntype,
	// Fetch
	input  logic [l15_pkg::rqtype_w-1:0]  if_rqtype,
	input  logic [l15_pkg::size_w-1:0]    if_size,
	input  logic [addr_w-1:0]             if_address,
	input  logic [data_w-1:0]             if_data,
	input  logic                          if_val,
	input  logic                          if_req_ack,
	output logic                          if_ack,
	output logic                          if_header_ack,
	output logic                          if_resp_val,
	output logic [data_w-1:0]             if_data_0,
	output logic [data_w-1:0]             if_data_1,
	output logic [l15_pkg::rettype_w-1:0] if_returntype,
	output logic                          if_hold,
	// Data memory
	input  logic [l15_pkg::rqtype_w-1:0]  dm_rqtype,
	input  logic [l15_pkg::size_w-1:0]    dm_size,
	input  logic [addr_w-1:0]             dm_address,
	input  logic [data_w-1:0]             dm_data,
	input  logic                          dm_val,
	input  logic                          dm_req_ack,
	input  logic                          dm_pending,
	output logic                          dm_ack,
	output logic                          dm_header_ack,
	output logic                          dm_resp_val,
	output logic [data_w-1:0]             dm_data_0,
	output logic [data_w-1:0]             dm_data_1,
	output logic [l15_pkg::rettype_w-1:0] dm_returntype,
	output logic                          dm_grant,
	// APB
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [l15_pkg::apb_aw-1:0]    paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr
);
	import l15_pkg::*;

	arb_state_t state;
	logic       data_en;
	logic       win_done;

	l15_arb_ctrl arb_ctrl_i (
		.clk          (clk),
		.nrst         (nrst),
		.dm_pending   (dm_pending),
		.data_en      (data_en),
		.if_val       (if_val),
		.l15_ack      (l15_ack),
		.l15_resp_val (l15_resp_val),
		.state        (state),
		.dm_grant     (dm_grant),
		.if_hold      (if_hold),
		.win_done     (win_done)
	);

	l15_port_steer #(
		.addr_w (addr_w),
		.data_w (data_w)
	) port_steer_i (
		.state          (state),
		.l15_rqtype     (l15_rqtype),
		.l15_size       (l15_size),
		.l15_address    (l15_address),
		.l15_data       (l15_data),
		.l15_val        (l15_val),
		.l15_req_ack    (l15_req_ack),
		.l15_ack        (l15_ack),
		.l15_header_ack (l15_header_ack),
		.l15_resp_val   (l15_resp_val),
		.l15_data_0     (l15_data_0),
		.l15_data_1     (l15_data_1),
		.l15_returntype (l15_returntype),
		.if_rqtype      (if_rqtype),
		.if_size        (if_size),
		.if_address     (if_address),
		.if_data        (if_data),
		.if_val         (if_val),
		.if_req_ack     (if_req_ack),
		.if_ack         (if_ack),
		.if_header_ack  (if_header_ack),
		.if_resp_val    (if_resp_val),
		.if_data_0      (if_data_0),
		.if_data_1      (if_data_1),
		.if_returntype  (if_returntype),
		.dm_rqtype      (dm_rqtype),
		.dm_size        (dm_size),
		.dm_address     (dm_address),
		.dm_data        (dm_data),
		.dm_val         (dm_val),
		.dm_req_ack     (dm_req_ack),
		.dm_ack         (dm_ack),
		.dm_header_ack  (dm_header_ack),
		.dm_resp_val    (dm_resp_val),
		.dm_data_0      (dm_data_0),
		.dm_data_1      (dm_data_1),
		.dm_returntype  (dm_returntype)
	);

	// Counts fetch responses as seen after steering
	l15_arb_regs arb_regs_i (
		.clk         (clk),
		.nrst        (nrst),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.win_done    (win_done),
		.if_resp_val (if_resp_val),
		.data_en     (data_en)
	);

endmodule

`default_nettype wire

// ==== rtl/l15_arb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module l15_arb_regs (
	input  logic                      clk,
	input  logic                      nrst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [l15_pkg::apb_aw-1:0] paddr,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      win_done,
	input  logic                      if_resp_val,
	output logic                      data_en
);
	import l15_pkg::*;

	logic [31:0] dwin_cnt;
	logic [31:0] iresp_cnt;
	logic        access;
	logic        wr_en;
	logic        addr_hit;

	assign access = psel && penable;
	assign wr_en  = access && pwrite;
	assign pready = 1'b1;  // No wait states

	// Read mux and address decode
	always_comb
	begin
		prdata   = '0;
		addr_hit = 1'b1;
		case (paddr)
			reg_ctrl:
				prdata = {31'd0, data_en};
			reg_dwin:
				prdata = dwin_cnt;
			reg_iresp:
				prdata = iresp_cnt;
			default:
				addr_hit = 1'b0;
		endcase
	end

	assign pslverr = access && !addr_hit;

	// Data enable comes out of reset set
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			data_en <= 1'b1;
		else if (wr_en && paddr == reg_ctrl)
			data_en <= pwdata[0];
	end

	// Any write clears a counter
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			dwin_cnt  <= '0;
			iresp_cnt <= '0;
		end
		else
		begin
			if (wr_en && paddr == reg_dwin)
				dwin_cnt <= '0;
			else if (win_done)
				dwin_cnt <= dwin_cnt + 32'd1;

			if (wr_en && paddr == reg_iresp)
				iresp_cnt <= '0;
			else if (if_resp_val)  // One per forwarded cycle
				iresp_cnt <= iresp_cnt + 32'd1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/l15_port_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

module l15_port_steer #(
	parameter int addr_w = 32,
	parameter int data_w = 64
) (
	input  l15_pkg::arb_state_t           state,
	// Shared port
	output logic [l15_pkg::rqtype_w-1:0]  l15_rqtype,
	output logic [l15_pkg::size_w-1:0]    l15_size,
	output logic [addr_w-1:0]             l15_address,
	output logic [data_w-1:0]             l15_data,
	output logic                          l15_val,
	output logic                          l15_req_ack,
	input  logic                          l15_ack,
	input  logic                          l15_header_ack,
	input  logic                          l15_resp_val,
	input  logic [data_w-1:0]             l15_data_0,
	input  logic [data_w-1:0]             l15_data_1,
	input  logic [l15_pkg::rettype_w-1:0] l15_returntype,
	// Fetch client
	input  logic [l15_pkg::rqtype_w-1:0]  if_rqtype,
	input  logic [l15_pkg::size_w-1:0]    if_size,
	input  logic [addr_w-1:0]             if_address,
	input  logic [data_w-1:0]             if_data,
	input  logic                          if_val,
	input  logic                          if_req_ack,
	output logic                          if_ack,
	output logic                          if_header_ack,
	output logic                          if_resp_val,
	output logic [data_w-1:0]             if_data_0,
	output logic [data_w-1:0]             if_data_1,
	output logic [l15_pkg::rettype_w-1:0] if_returntype,
	// Data memory client
	input  logic [l15_pkg::rqtype_w-1:0]  dm_rqtype,
	input  logic [l15_pkg::size_w-1:0]    dm_size,
	input  logic [addr_w-1:0]             dm_address,
	input  logic [data_w-1:0]             dm_data,
	input  logic                          dm_val,
	input  logic                          dm_req_ack,
	output logic                          dm_ack,
	output logic                          dm_header_ack,
	output logic                          dm_resp_val,
	output logic [data_w-1:0]             dm_data_0,
	output logic [data_w-1:0]             dm_data_1,
	output logic [l15_pkg::rettype_w-1:0] dm_returntype
);
	import l15_pkg::*;

	logic mem_own;

	assign mem_own = (state == arb_mem);

	// Request fields follow the owner, fetch while waiting
	assign l15_rqtype  = mem_own ? dm_rqtype  : if_rqtype;
	assign l15_size    = mem_own ? dm_size    : if_size;
	assign l15_address = mem_own ? dm_address : if_address;
	assign l15_data    = mem_own ? dm_data    : if_data;

	// Response payload goes to both, only the valid is steered
	assign if_data_0     = l15_data_0;
	assign if_data_1     = l15_data_1;
	assign if_returntype = l15_returntype;
	assign dm_data_0     = l15_data_0;
	assign dm_data_1     = l15_data_1;
	assign dm_returntype = l15_returntype;

	always_comb
	begin
		l15_val       = 1'b0;
		if_ack        = 1'b0;
		if_header_ack = 1'b0;
		dm_ack        = 1'b0;
		dm_header_ack = 1'b0;
		if_resp_val   = l15_resp_val;  // Fetch drains in INSTR and WAIT
		dm_resp_val   = 1'b0;
		l15_req_ack   = if_req_ack;
		case (state)
			arb_instr:
			begin
				l15_val       = if_val;
				if_ack        = l15_ack;
				if_header_ack = l15_header_ack;
			end
			arb_mem:
			begin
				l15_val       = dm_val;
				dm_ack        = l15_ack;
				dm_header_ack = l15_header_ack;
				if_resp_val   = 1'b0;
				dm_resp_val   = l15_resp_val;
				l15_req_ack   = dm_req_ack;
			end
			default:
			begin
				l15_val = 1'b0;  // WAIT, port looks busy to both
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/l15_arb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module l15_arb_ctrl (
	input  logic                clk,
	input  logic                nrst,
	input  logic                dm_pending,
	input  logic                data_en,
	input  logic                if_val,
	input  logic                l15_ack,
	input  logic                l15_resp_val,
	output l15_pkg::arb_state_t state,
	output logic                dm_grant,
	output logic                if_hold,
	output logic                win_done
);
	import l15_pkg::*;

	arb_state_t next_state;
	logic [3:0] if_out_cnt;  // Fetch requests acked, response still due
	logic       if_issue;
	logic       if_retire;
	logic       mem_done;

	// Fetch handshakes only count while fetch sees the port
	assign if_issue  = (state == arb_instr) && if_val && l15_ack;
	assign if_retire = (state != arb_mem) && l15_resp_val;

	// Data side finished and nothing else queued
	assign mem_done = (state == arb_mem) && (l15_resp_val || l15_ack) && !dm_pending;

	always_comb
	begin
		next_state = state;
		case (state)
			arb_instr:
			begin
				if (dm_pending && data_en)
					next_state = arb_wait;
			end
			arb_wait:
			begin
				if (if_out_cnt == '0)  // Drained
					next_state = arb_mem;
			end
			arb_mem:
			begin
				if (mem_done)
					next_state = arb_instr;
			end
			default:
				next_state = arb_instr;
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state      <= arb_instr;
			if_out_cnt <= '0;
			win_done   <= 1'b0;
		end
		else
		begin
			state    <= next_state;
			win_done <= mem_done;
			// Issue and retire in one cycle cancel out
			if (if_issue && !if_retire)
				if_out_cnt <= if_out_cnt + 4'd1;
			else if (if_retire && !if_issue)
				if_out_cnt <= if_out_cnt - 4'd1;
		end
	end

	assign dm_grant = (state == arb_mem);
	assign if_hold  = (state != arb_instr);  // Also covers MEM

endmodule

`default_nettype wire

// ==== rtl/l15_pkg.sv ====
`default_nettype none

package l15_pkg;

	// L1.5 request and response field widths
	localparam int rqtype_w  = 5;
	localparam int size_w    = 3;
	localparam int rettype_w = 4;

	// Who drives the shared port
	typedef enum logic [1:0] {
		arb_instr = 2'd0,  // Fetch owns the port
		arb_wait  = 2'd1,  // Data op pending, fetch responses drain
		arb_mem   = 2'd2   // Data memory owns the port
	} arb_state_t;

	localparam int apb_aw = 4;

	// APB register byte offsets
	localparam logic [apb_aw-1:0] reg_ctrl  = 4'h0;
	localparam logic [apb_aw-1:0] reg_dwin  = 4'h4;  // Data window count
	localparam logic [apb_aw-1:0] reg_iresp = 4'h8;  // Fetch response count

endpackage

`default_nettype wire
